// File: design/soc_io_defines.svh
`ifndef SOC_IO_DEFINES_SVH
`define SOC_IO_DEFINES_SVH

// ==============================
// Data path widths
// ==============================

`define SOC_IO_DATA_WIDTH 32

// 4 KB data memory, word organised
`define SOC_IO_DMEM_WORDS 1024
`define SOC_IO_DMEM_ADDR_WIDTH 10

// ==============================
// Memory mapped I/O
// ==============================

// Byte write here sends one UART frame
`define SOC_IO_UART_TX_ADDR 32'h8000_0000

// Read returns the UART status word
`define SOC_IO_UART_STAT_ADDR 32'h8000_0001

// Busy flag position in the status word
`define SOC_IO_STAT_BUSY_BIT 8

// Kept short for simulation
`define SOC_IO_CLKS_PER_BIT 8

`endif

// File: design/soc_io_pkg.sv
`include "soc_io_defines.svh"

package soc_io_pkg;

    // ==============================
    // Core and memory data types
    // ==============================

    // One data word
    typedef logic [`SOC_IO_DATA_WIDTH-1:0] word_t;

    // Core side byte address
    typedef logic [31:0] byte_addr_t;

    // Data memory word index
    typedef logic [`SOC_IO_DMEM_ADDR_WIDTH-1:0] word_idx_t;

    // One enable per byte lane
    typedef logic [`SOC_IO_DATA_WIDTH/8-1:0] be_t;

    // UART transmitter frame states
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

endpackage

// File: design/dp_sram.sv
`timescale 1ns/1ps
`include "soc_io_defines.svh"

module dp_sram (
    input  logic                  clk,
    input  logic                  arst_n_i,
    // Port 0, external preload and readback
    input  logic                  ext_req_i,
    input  logic                  ext_we_i,
    input  soc_io_pkg::word_idx_t ext_idx_i,
    input  soc_io_pkg::word_t     ext_wdata_i,
    input  soc_io_pkg::be_t       ext_be_i,
    output soc_io_pkg::word_t     ext_rdata_o,
    // Port 1, core side
    input  logic                  loc_req_i,
    input  logic                  loc_we_i,
    input  soc_io_pkg::word_idx_t loc_idx_i,
    input  soc_io_pkg::word_t     loc_wdata_i,
    input  soc_io_pkg::be_t       loc_be_i,
    output soc_io_pkg::word_t     loc_rdata_o
);

    localparam int LANES  = $bits(soc_io_pkg::be_t);
    localparam int BYTE_W = 8;

    soc_io_pkg::word_t mem_q [`SOC_IO_DMEM_WORDS];

    logic ext_wr;
    logic loc_wr;
    logic ext_rd;
    logic loc_rd;

    assign ext_wr = ext_req_i && ext_we_i;
    assign loc_wr = loc_req_i && loc_we_i;
    assign ext_rd = ext_req_i && !ext_we_i;
    assign loc_rd = loc_req_i && !loc_we_i;

    // ==============================
    // Byte lane writes
    // ==============================

    // Port 1 is applied last, so it wins on a shared lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < LANES; b++) begin
            if (ext_wr && ext_be_i[b]) begin
                mem_q[ext_idx_i][b*BYTE_W +: BYTE_W] <= ext_wdata_i[b*BYTE_W +: BYTE_W];
            end
        end
        for (int b = 0; b < LANES; b++) begin
            if (loc_wr && loc_be_i[b]) begin
                mem_q[loc_idx_i][b*BYTE_W +: BYTE_W] <= loc_wdata_i[b*BYTE_W +: BYTE_W];
            end
        end
    end

    // ==============================
    // Registered reads
    // ==============================

    // Each port keeps its last read word until the next read
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ext_rdata_o <= '0;
            loc_rdata_o <= '0;
        end else begin
            if (ext_rd) begin
                ext_rdata_o <= mem_q[ext_idx_i];
            end
            if (loc_rd) begin
                loc_rdata_o <= mem_q[loc_idx_i];
            end
        end
    end

endmodule

// File: design/baud_timer.sv
`timescale 1ns/1ps
`include "soc_io_defines.svh"

module baud_timer (
    input  logic clk,
    input  logic arst_n_i,
    input  logic run_i,
    output logic bit_tick_o
);

    localparam int CNT_W = $clog2(`SOC_IO_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`SOC_IO_CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             wrap;

    assign wrap = (cnt_q == LAST);

    // Restarts from zero whenever the transmitter goes idle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;
        end else if (wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Last cycle of each bit period
    assign bit_tick_o = run_i && wrap;

endmodule

// File: design/uart_tx_fsm.sv
`timescale 1ns/1ps

module uart_tx_fsm (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       tx_start_i,
    input  logic [7:0] tx_byte_i,
    input  logic       bit_tick_i,
    output logic       tx_o,
    output logic       tx_busy_o,
    output logic       baud_run_o
);

    soc_io_pkg::tx_state_t state_q;

    logic [7:0] shift_q;
    logic [2:0] bit_cnt_q;
    logic       tx_q;

    // ==============================
    // Frame sequencing
    // ==============================

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= soc_io_pkg::IDLE;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            case (state_q)
                soc_io_pkg::IDLE: begin
                    if (tx_start_i) begin
                        state_q <= soc_io_pkg::START;
                        tx_q    <= 1'b0;
                    end
                end
                soc_io_pkg::START: begin
                    if (bit_tick_i) begin
                        state_q   <= soc_io_pkg::DATA;
                        bit_cnt_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                soc_io_pkg::DATA: begin
                    if (bit_tick_i) begin
                        // Eighth data bit done, line goes high for stop
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= soc_io_pkg::STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            tx_q      <= shift_q[0];
                        end
                    end
                end
                soc_io_pkg::STOP: begin
                    if (bit_tick_i) begin
                        state_q <= soc_io_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= soc_io_pkg::IDLE;
                    tx_q    <= 1'b1;
                end
            endcase
        end
    end

    // ==============================
    // Data shifter
    // ==============================

    // LSB first, next bit always sits in shift_q[0]
    always_ff @(posedge clk) begin
        if (state_q == soc_io_pkg::IDLE && tx_start_i) begin
            shift_q <= tx_byte_i;
        end else if (bit_tick_i && state_q inside {soc_io_pkg::START, soc_io_pkg::DATA}) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign tx_o       = tx_q;
    assign tx_busy_o  = (state_q != soc_io_pkg::IDLE);
    assign baud_run_o = (state_q != soc_io_pkg::IDLE);

endmodule

// File: design/dmem_io_router.sv
`timescale 1ns/1ps
`include "soc_io_defines.svh"

module dmem_io_router (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // Core data port
    input  logic                   core_req_i,
    input  logic                   core_we_i,
    input  soc_io_pkg::byte_addr_t core_addr_i,
    input  soc_io_pkg::word_t      core_wdata_i,
    input  soc_io_pkg::be_t        core_be_i,
    output soc_io_pkg::word_t      core_rdata_o,
    // Data memory local port
    input  soc_io_pkg::word_t      mem_rdata_i,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output soc_io_pkg::word_idx_t  mem_idx_o,
    output soc_io_pkg::word_t      mem_wdata_o,
    output soc_io_pkg::be_t        mem_be_o,
    // UART transmitter
    input  logic                   tx_busy_i,
    output logic                   tx_start_o,
    output logic [7:0]             tx_byte_o
);

    logic              in_window;
    logic              is_tx;
    logic              is_stat;
    logic              io_read_q;
    soc_io_pkg::word_t stat_d;
    soc_io_pkg::word_t stat_q;

    // ==============================
    // Address decode
    // ==============================

    // Memory window is the low 4 MB
    assign in_window = ~|core_addr_i[31:22];
    assign is_tx     = (core_addr_i == `SOC_IO_UART_TX_ADDR);
    assign is_stat   = (core_addr_i == `SOC_IO_UART_STAT_ADDR);

    // Reads always go to memory, writes only inside the window
    assign mem_req_o   = core_req_i && (!core_we_i || in_window);
    assign mem_we_o    = core_we_i && in_window;
    assign mem_idx_o   = core_addr_i[`SOC_IO_DMEM_ADDR_WIDTH+1:2];
    assign mem_wdata_o = core_wdata_i;
    assign mem_be_o    = core_be_i;

    // Writes while a frame is running are lost
    assign tx_start_o = core_req_i && core_we_i && is_tx && !tx_busy_i;
    assign tx_byte_o  = core_wdata_i[7:0];

    // ==============================
    // Status read path
    // ==============================

    // No receiver, so the RX byte field stays zero
    always_comb begin
        stat_d = '0;
        stat_d[`SOC_IO_STAT_BUSY_BIT] = tx_busy_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            io_read_q <= 1'b0;
            stat_q    <= '0;
        end else begin
            io_read_q <= core_req_i && !core_we_i && is_stat;
            if (core_req_i && !core_we_i && is_stat) begin
                stat_q <= stat_d;
            end
        end
    end

    // Same latency as the memory read register
    assign core_rdata_o = io_read_q ? stat_q : mem_rdata_i;

endmodule

// File: design/soc_io_top.sv
`timescale 1ns/1ps

module soc_io_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // Core data port
    input  logic                   core_req_i,
    input  logic                   core_we_i,
    input  soc_io_pkg::byte_addr_t core_addr_i,
    input  soc_io_pkg::word_t      core_wdata_i,
    input  soc_io_pkg::be_t        core_be_i,
    output soc_io_pkg::word_t      core_rdata_o,
    // External memory port
    input  logic                   ext_req_i,
    input  logic                   ext_we_i,
    input  soc_io_pkg::word_idx_t  ext_addr_i,
    input  soc_io_pkg::word_t      ext_wdata_i,
    input  soc_io_pkg::be_t        ext_be_i,
    output soc_io_pkg::word_t      ext_rdata_o,
    // Serial line
    output logic                   uart_tx_o
);

    // Router to memory local port
    logic                  mem_req;
    logic                  mem_we;
    soc_io_pkg::word_idx_t mem_idx;
    soc_io_pkg::word_t     mem_wdata;
    soc_io_pkg::be_t       mem_be;
    soc_io_pkg::word_t     mem_rdata;

    // UART control
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       baud_run;
    logic       bit_tick;

    dmem_io_router router0 (
        .clk         (clk         ),
        .arst_n_i    (arst_n_i    ),
        .core_req_i  (core_req_i  ),
        .core_we_i   (core_we_i   ),
        .core_addr_i (core_addr_i ),
        .core_wdata_i(core_wdata_i),
        .core_be_i   (core_be_i   ),
        .core_rdata_o(core_rdata_o),
        .mem_rdata_i (mem_rdata   ),
        .mem_req_o   (mem_req     ),
        .mem_we_o    (mem_we      ),
        .mem_idx_o   (mem_idx     ),
        .mem_wdata_o (mem_wdata   ),
        .mem_be_o    (mem_be      ),
        .tx_busy_i   (tx_busy     ),
        .tx_start_o  (tx_start    ),
        .tx_byte_o   (tx_byte     )
    );

    dp_sram dmem0 (
        .clk        (clk        ),
        .arst_n_i   (arst_n_i   ),
        .ext_req_i  (ext_req_i  ),
        .ext_we_i   (ext_we_i   ),
        .ext_idx_i  (ext_addr_i ),
        .ext_wdata_i(ext_wdata_i),
        .ext_be_i   (ext_be_i   ),
        .ext_rdata_o(ext_rdata_o),
        .loc_req_i  (mem_req    ),
        .loc_we_i   (mem_we     ),
        .loc_idx_i  (mem_idx    ),
        .loc_wdata_i(mem_wdata  ),
        .loc_be_i   (mem_be     ),
        .loc_rdata_o(mem_rdata  )
    );

    uart_tx_fsm uart_tx0 (
        .clk       (clk      ),
        .arst_n_i  (arst_n_i ),
        .tx_start_i(tx_start ),
        .tx_byte_i (tx_byte  ),
        .bit_tick_i(bit_tick ),
        .tx_o      (uart_tx_o),
        .tx_busy_o (tx_busy  ),
        .baud_run_o(baud_run )
    );

    baud_timer baud0 (
        .clk       (clk     ),
        .arst_n_i  (arst_n_i),
        .run_i     (baud_run),
        .bit_tick_o(bit_tick)
    );

endmodule

// File: verification/soc_io_props.sv
`timescale 1ns/1ps

module soc_io_props (
    input logic              clk,
    input logic              arst_n_i,
    input logic              uart_tx_i,
    input logic              tx_busy_i,
    input logic              tx_start_i,
    input logic              core_req_i,
    input logic              ext_req_i,
    input soc_io_pkg::word_t core_rdata_i,
    input soc_io_pkg::word_t ext_rdata_i
);

    // Failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Line idles high between frames
    idle_line_high: assert property (@(posedge clk) disable iff (!arst_n_i)
        !tx_busy_i |-> uart_tx_i)
        else begin
            $error("uart_tx_o low while transmitter idle");
            fail_count++;
        end

    start_sets_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        tx_start_i |=> tx_busy_i)
        else begin
            $error("accepted start did not raise busy");
            fail_count++;
        end

    // ==============================
    // Read data
    // ==============================

    core_rdata_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        core_req_i |=> !$isunknown(core_rdata_i))
        else begin
            $error("core_rdata_o unknown after request");
            fail_count++;
        end

    ext_rdata_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        ext_req_i |=> !$isunknown(ext_rdata_i))
        else begin
            $error("ext_rdata_o unknown after request");
            fail_count++;
        end

endmodule

bind soc_io_top soc_io_props props0 (
    .clk         (clk         ),
    .arst_n_i    (arst_n_i    ),
    .uart_tx_i   (uart_tx_o   ),
    .tx_busy_i   (tx_busy     ),
    .tx_start_i  (tx_start    ),
    .core_req_i  (core_req_i  ),
    .ext_req_i   (ext_req_i   ),
    .core_rdata_i(core_rdata_o),
    .ext_rdata_i (ext_rdata_o )
);

// File: verification/soc_io_tb.sv
`timescale 1ns/1ps
`include "soc_io_defines.svh"

module soc_io_tb;

    localparam int WORDS  = `SOC_IO_DMEM_WORDS;
    localparam int CLKS   = `SOC_IO_CLKS_PER_BIT;
    localparam int FRAME  = 10 * CLKS;
    localparam int N_EXT  = 200;
    localparam int N_CORE = 300;
    localparam int N_DUAL = 50;
    // Preload, random phases, three frames and the dropped writes, plus margin
    localparam int WD_CYCLES = WORDS + 2 * N_EXT + N_CORE + 2 * N_DUAL
                             + 3 * FRAME + 5 * CLKS + 500;

    logic                  clk;
    logic                  arst_n_i;
    logic                  core_req_i;
    logic                  core_we_i;
    soc_io_pkg::byte_addr_t core_addr_i;
    soc_io_pkg::word_t     core_wdata_i;
    soc_io_pkg::be_t       core_be_i;
    soc_io_pkg::word_t     core_rdata_o;
    logic                  ext_req_i;
    logic                  ext_we_i;
    soc_io_pkg::word_idx_t ext_addr_i;
    soc_io_pkg::word_t     ext_wdata_i;
    soc_io_pkg::be_t       ext_be_i;
    soc_io_pkg::word_t     ext_rdata_o;
    logic                  uart_tx_o;

    // Reference model and checker state
    logic [31:0] model_mem [WORDS];
    int          busy_cnt = 0;
    bit          tx_accept = 1'b0;
    logic [7:0]  exp_q [$];
    logic [7:0]  rx_q [$];
    bit          core_pend = 1'b0;
    bit          ext_pend = 1'b0;
    logic [31:0] core_exp;
    logic [31:0] ext_exp;
    logic [31:0] core_obs;
    integer      seed;
    int          errors = 0;
    int          test_start_err = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    soc_io_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        errors++;
    endtask

    task automatic model_write(input soc_io_pkg::word_idx_t idx, input logic [31:0] d,
                               input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) model_mem[idx][8*b +: 8] = d[8*b +: 8];
        end
    endtask

    // ==============================
    // Cycle stepping and port drivers
    // ==============================

    // Checks the reads issued in the cycle that just ended, then idles both ports
    task automatic tick();
        @(posedge clk);
        #1;
        core_obs = core_rdata_o;
        if (core_pend && core_rdata_o !== core_exp)
            report_mismatch("core_rdata_o", core_rdata_o, core_exp);
        if (ext_pend && ext_rdata_o !== ext_exp)
            report_mismatch("ext_rdata_o", ext_rdata_o, ext_exp);
        core_pend = 1'b0;
        ext_pend  = 1'b0;
        if (busy_cnt > 0) busy_cnt--;
        if (tx_accept) begin
            busy_cnt  = FRAME;
            tx_accept = 1'b0;
        end
        core_req_i = 1'b0;
        ext_req_i  = 1'b0;
    endtask

    task automatic ext_op(input bit we, input soc_io_pkg::word_idx_t idx,
                          input logic [31:0] wdata, input logic [3:0] be);
        ext_req_i   = 1'b1;
        ext_we_i    = we;
        ext_addr_i  = idx;
        ext_wdata_i = wdata;
        ext_be_i    = be;
        if (we) begin
            model_write(idx, wdata, be);
        end else begin
            ext_pend = 1'b1;
            ext_exp  = model_mem[idx];
        end
    endtask

    task automatic core_op(input bit we, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be);
        core_req_i   = 1'b1;
        core_we_i    = we;
        core_addr_i  = addr;
        core_wdata_i = wdata;
        core_be_i    = be;
        if (!we) begin
            core_pend = 1'b1;
            core_exp  = (addr == `SOC_IO_UART_STAT_ADDR) ? {23'd0, busy_cnt > 0, 8'd0}
                                                        : model_mem[addr[11:2]];
        end else if (~|addr[31:22]) begin
            model_write(addr[11:2], wdata, be);
        end else if (addr == `SOC_IO_UART_TX_ADDR && busy_cnt == 0) begin
            tx_accept = 1'b1;
            exp_q.push_back(wdata[7:0]);
        end
    endtask

    // Status reads every cycle until the busy bit drops
    task automatic poll_until_idle(output bit seen_busy);
        int n;
        n = 0;
        seen_busy = 1'b0;
        do begin
            core_op(1'b0, `SOC_IO_UART_STAT_ADDR, '0, '0);
            tick();
            seen_busy |= core_obs[8];
            n++;
        end while (core_obs[8] && n < 2 * FRAME);
        if (core_obs[8]) begin
            $display("UART busy bit never cleared after %0d status reads", n);
            errors++;
        end
    endtask

    task automatic check_uart_bytes();
        int waited;
        logic [7:0] got;
        waited = 0;
        while (rx_q.size() < exp_q.size() && waited < 2 * FRAME) begin
            tick();
            waited++;
        end
        if (rx_q.size() != exp_q.size()) begin
            $display("UART decoder holds %0d bytes where %0d were accepted",
                     rx_q.size(), exp_q.size());
            errors++;
        end
        while (rx_q.size() > 0 && exp_q.size() > 0) begin
            got = rx_q.pop_front();
            if (got !== exp_q[0]) report_mismatch("uart_tx_o byte", 32'(got), 32'(exp_q[0]));
            void'(exp_q.pop_front());
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - test_start_err;
        $display("%s: %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
        if (n != 0) tests_failed++;
        tests_run++;
        test_start_err = errors;
    endtask

    // ==============================
    // UART line decoder
    // ==============================

    initial begin : uart_decoder
        logic [7:0] rx_byte;
        forever begin
            @(negedge uart_tx_o);
            // Move to the middle of the start bit
            repeat (CLKS / 2) @(negedge clk);
            if (uart_tx_o !== 1'b0) begin
                $display("UART start bit did not stay low to mid-bit");
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk);
                rx_byte[i] = uart_tx_o;
            end
            repeat (CLKS) @(negedge clk);
            if (uart_tx_o !== 1'b1) begin
                $display("UART stop bit was not high");
                errors++;
            end
            rx_q.push_back(rx_byte);
        end
    end

    initial begin : watchdog
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================

    initial begin : main
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] addr;
        bit          seen;
        seed         = 32'h6c83_778c;
        arst_n_i     = 1'b0;
        core_req_i   = 1'b0;
        core_we_i    = 1'b0;
        core_addr_i  = '0;
        core_wdata_i = '0;
        core_be_i    = '0;
        ext_req_i    = 1'b0;
        ext_we_i     = 1'b0;
        ext_addr_i   = '0;
        ext_wdata_i  = '0;
        ext_be_i     = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        // Test 1, reset values, then word 0 is cleared since it is read behind the status
        if (uart_tx_o !== 1'b1) report_mismatch("uart_tx_o", 32'(uart_tx_o), 32'h1);
        if (core_rdata_o !== '0) report_mismatch("core_rdata_o", core_rdata_o, '0);
        if (ext_rdata_o !== '0) report_mismatch("ext_rdata_o", ext_rdata_o, '0);
        ext_op(1'b1, '0, '0, 4'hf);
        tick();
        core_op(1'b0, `SOC_IO_UART_STAT_ADDR, '0, '0);
        tick();
        end_test("test 1 reset state");

        // Test 2, full preload, partial writes, back-to-back reads
        for (int i = 0; i < WORDS; i++) begin
            ext_op(1'b1, i[9:0], rand32(), 4'hf);
            tick();
        end
        for (int i = 0; i < N_EXT; i++) begin
            r = rand32();
            ext_op(1'b1, r[9:0], rand32(), r[13:10]);
            tick();
        end
        for (int i = 0; i < N_EXT; i++) begin
            r = rand32();
            ext_op(1'b0, r[9:0], '0, '0);
            tick();
        end
        end_test("test 2 external writes and reads");

        // Test 3, odd upper address bits keep clear of the I/O addresses
        for (int i = 0; i < N_CORE; i++) begin
            r = rand32();
            d = rand32();
            addr = {(r[31:30] == 2'b00) ? {r[29:21], 1'b1} : 10'd0, r[20:11], r[10:1], 2'b00};
            ext_op(1'b0, r[10:1], '0, '0);
            core_op(r[0], addr, rand32(), d[3:0]);
            tick();
        end
        end_test("test 3 core window and readback");

        // Test 4, one frame with status polling
        core_op(1'b1, `SOC_IO_UART_TX_ADDR, rand32(), 4'h1);
        tick();
        poll_until_idle(seen);
        if (!seen) begin
            $display("UART status never showed busy during the frame");
            errors++;
        end
        check_uart_bytes();
        end_test("test 4 UART transmit");

        // Test 5, writes while busy are lost
        core_op(1'b1, `SOC_IO_UART_TX_ADDR, rand32(), 4'h1);
        tick();
        for (int i = 0; i < 5; i++) begin
            repeat (CLKS - 1) tick();
            core_op(1'b1, `SOC_IO_UART_TX_ADDR, rand32(), 4'h1);
            tick();
        end
        poll_until_idle(seen);
        core_op(1'b1, `SOC_IO_UART_TX_ADDR, rand32(), 4'h1);
        tick();
        poll_until_idle(seen);
        check_uart_bytes();
        end_test("test 5 UART writes while busy");

        // Test 6, same word from both ports in one cycle
        for (int i = 0; i < N_DUAL; i++) begin
            r = rand32();
            d = rand32();
            ext_op(1'b1, r[9:0], rand32(), d[3:0]);
            core_op(1'b1, {20'd0, r[9:0], 2'b00}, rand32(), d[7:4]);
            tick();
            ext_op(1'b0, r[9:0], '0, '0);
            core_op(1'b0, {20'd0, r[9:0], 2'b00}, '0, '0);
            tick();
        end
        end_test("test 6 simultaneous writes");

        errors += dut0.props0.fail_count;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+design
design/soc_io_pkg.sv
design/dp_sram.sv
design/baud_timer.sv
design/uart_tx_fsm.sv
design/dmem_io_router.sv
design/soc_io_top.sv
verification/soc_io_props.sv
verification/soc_io_tb.sv

// File: Makefile
TOP := soc_io_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	rm -f $(LOG)
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
